// File: logic/tlk_tx_pkg.sv
`default_nettype none

package tlk_tx_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [63:0] dma_word_t;
    typedef logic [15:0] line_word_t;
    typedef logic [15:0] byte_len_t;
    typedef logic [23:0] frame_cnt_t;
    typedef logic [19:0] gap_cnt_t;

    ////////////////////////////////////////////////////////////
    // line symbols
    ////////////////////////////////////////////////////////////

    // D5.6 on the msb byte, K28.5 on the lsb byte
    localparam line_word_t COMMA_WORD     = 16'hC5BC;
    // K28.2 / K27.7
    localparam line_word_t SOF_WORD       = 16'h5CFB;
    // K29.7 / K30.7
    localparam line_word_t EOF_WORD       = 16'hFDFE;
    localparam line_word_t HEAD0_WORD     = 16'hEB90;
    localparam line_word_t HEAD1_WORD     = 16'hE116;
    localparam line_word_t SIGN_WORD      = 16'h8100;
    localparam line_word_t SIGN_LAST_WORD = 16'h8101;

    typedef enum logic [3:0] {
        sym_idle, sym_sof, sym_head0, sym_head1, sym_sign, sym_sign_last,
        sym_number, sym_length, sym_data, sym_checksum, sym_eof
    } sym_kind_e;

    typedef enum logic [3:0] {
        st_pwr_sync, st_idle, st_sync, st_start_frame, st_frame_head,
        st_file_sign, st_frame_num, st_vld_dlen, st_vld_data,
        st_frame_tail, st_end_frame, st_gap, st_interrupt
    } tx_state_e;

    // payload only matters for number, length and data
    typedef struct packed {
        sym_kind_e  kind;
        line_word_t payload;
    } tx_sym_t;

endpackage

`default_nettype wire

// File: logic/tlk_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_fifo #(
    parameter int ADDR_W = 9
) (
    input  logic                  clk,
    input  logic                  i_soft_reset,
    input  logic                  i_wr_en,
    input  tlk_tx_pkg::dma_word_t i_wr_data,
    input  logic                  i_pop,
    output tlk_tx_pkg::dma_word_t o_head,
    output logic                  o_not_empty,
    output logic                  o_full
);

    localparam int DEPTH = 1 << ADDR_W;

    tlk_tx_pkg::dma_word_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              wr_ok;
    logic              rd_ok;

    // writes into a full FIFO and pops from an empty one are dropped
    assign wr_ok = i_wr_en & ~o_full;
    assign rd_ok = i_pop & o_not_empty;

    assign o_not_empty = (count != '0);
    assign o_full      = (count == (ADDR_W + 1)'(DEPTH));

    // first word fall through, head is always on the output
    assign o_head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/tlk_lane_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_lane_unpacker (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  tlk_tx_pkg::dma_word_t  i_head,
    input  logic                   i_not_empty,
    input  logic                   i_lane_next,
    input  logic                   i_frame_end,
    output tlk_tx_pkg::line_word_t o_lane,
    output logic                   o_lane_valid,
    output logic                   o_pop
);

    logic [1:0] lane_idx;
    logic       last_lane;
    logic       partial;

    // lane 0 sits in bits 15:0
    assign o_lane       = i_head[{lane_idx, 4'b0000} +: 16];
    assign o_lane_valid = i_not_empty;

    assign last_lane = i_lane_next & (lane_idx == 2'd3);
    // frame ended part way through a word, the rest is dropped
    assign partial   = i_frame_end & (lane_idx != 2'd0);

    assign o_pop = i_not_empty & (last_lane | partial);

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            lane_idx <= 2'd0;
        end else if (i_frame_end) begin
            lane_idx <= 2'd0;
        end else if (i_lane_next) begin
            // wraps 3 -> 0 together with the pop
            lane_idx <= lane_idx + 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: logic/tlk_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_framer #(
    parameter int PWR_SYNC_CYCLES = 100,
    parameter int SYNC_CYCLES     = 6,
    parameter int GAP_CYCLES      = 257
) (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  tlk_tx_pkg::byte_len_t  i_tx_packet_body,
    input  tlk_tx_pkg::byte_len_t  i_tx_packet_tail,
    input  tlk_tx_pkg::frame_cnt_t i_tx_body_num,
    input  tlk_tx_pkg::line_word_t i_tx_intr_width,
    input  tlk_tx_pkg::line_word_t i_lane,
    input  logic                   i_lane_valid,
    output logic                   o_lane_next,
    output logic                   o_frame_end,
    output tlk_tx_pkg::tx_sym_t    o_sym,
    output logic                   o_tx_interrupt
);

    localparam tlk_tx_pkg::gap_cnt_t PWR_LAST  = tlk_tx_pkg::gap_cnt_t'(PWR_SYNC_CYCLES - 1);
    localparam tlk_tx_pkg::gap_cnt_t SYNC_LAST = tlk_tx_pkg::gap_cnt_t'(SYNC_CYCLES - 1);
    localparam tlk_tx_pkg::gap_cnt_t GAP_LAST  = tlk_tx_pkg::gap_cnt_t'(GAP_CYCLES - 1);

    tlk_tx_pkg::tx_state_e  state;
    tlk_tx_pkg::gap_cnt_t   period_cnt;
    tlk_tx_pkg::byte_len_t  frame_len;
    tlk_tx_pkg::byte_len_t  data_words;
    tlk_tx_pkg::byte_len_t  word_cnt;
    tlk_tx_pkg::frame_cnt_t frame_cnt;
    tlk_tx_pkg::line_word_t intr_cnt;
    logic                   start_r;
    logic                   start_pulse;
    logic                   start_armed;
    logic                   head_sel;
    logic                   last_frame;

    // two bytes per data word, odd lengths round up
    assign data_words = {1'b0, frame_len[15:1]} + {15'd0, frame_len[0]};

    assign o_lane_next = i_lane_valid &
                         (state == tlk_tx_pkg::st_vld_data || state == tlk_tx_pkg::st_interrupt);
    assign o_frame_end    = (state == tlk_tx_pkg::st_end_frame);
    assign o_tx_interrupt = (state == tlk_tx_pkg::st_interrupt);

    ////////////////////////////////////////////////////////////
    // start edge and start flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            start_r     <= 1'b0;
            start_pulse <= 1'b0;
            start_armed <= 1'b0;
        end else begin
            start_r     <= i_tx_start;
            start_pulse <= i_tx_start & ~start_r;
            if (start_pulse) begin
                start_armed <= 1'b1;
            end else if (state == tlk_tx_pkg::st_end_frame) begin
                start_armed <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // frame sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state      <= tlk_tx_pkg::st_pwr_sync;
            period_cnt <= '0;
            head_sel   <= 1'b0;
            word_cnt   <= '0;
            frame_cnt  <= '0;
            frame_len  <= '0;
            last_frame <= 1'b0;
            intr_cnt   <= '0;
            o_sym      <= '{kind: tlk_tx_pkg::sym_idle, payload: '0};
        end else begin
            period_cnt    <= '0;
            o_sym.kind    <= tlk_tx_pkg::sym_idle;
            o_sym.payload <= '0;
            case (state)
                tlk_tx_pkg::st_pwr_sync: begin
                    period_cnt <= period_cnt + 1'b1;
                    if (period_cnt == PWR_LAST) state <= tlk_tx_pkg::st_idle;
                end
                tlk_tx_pkg::st_idle: begin
                    intr_cnt <= '0;
                    if (start_armed && i_lane_valid) state <= tlk_tx_pkg::st_sync;
                end
                tlk_tx_pkg::st_sync: begin
                    period_cnt <= period_cnt + 1'b1;
                    if (period_cnt == SYNC_LAST) state <= tlk_tx_pkg::st_start_frame;
                end
                tlk_tx_pkg::st_start_frame: begin
                    o_sym.kind <= tlk_tx_pkg::sym_sof;
                    last_frame <= (frame_cnt == i_tx_body_num);
                    frame_len  <= (frame_cnt == i_tx_body_num) ? i_tx_packet_tail
                                                               : i_tx_packet_body;
                    head_sel   <= 1'b0;
                    state      <= tlk_tx_pkg::st_frame_head;
                end
                tlk_tx_pkg::st_frame_head: begin
                    o_sym.kind <= head_sel ? tlk_tx_pkg::sym_head1 : tlk_tx_pkg::sym_head0;
                    head_sel   <= ~head_sel;
                    if (head_sel) state <= tlk_tx_pkg::st_file_sign;
                end
                tlk_tx_pkg::st_file_sign: begin
                    o_sym.kind <= last_frame ? tlk_tx_pkg::sym_sign_last : tlk_tx_pkg::sym_sign;
                    state      <= tlk_tx_pkg::st_frame_num;
                end
                tlk_tx_pkg::st_frame_num: begin
                    o_sym.kind    <= tlk_tx_pkg::sym_number;
                    o_sym.payload <= frame_cnt[15:0];
                    state         <= tlk_tx_pkg::st_vld_dlen;
                end
                tlk_tx_pkg::st_vld_dlen: begin
                    o_sym.kind    <= tlk_tx_pkg::sym_length;
                    o_sym.payload <= frame_len;
                    word_cnt      <= '0;
                    // an empty frame goes straight to its checksum
                    state <= (data_words == '0) ? tlk_tx_pkg::st_frame_tail
                                                : tlk_tx_pkg::st_vld_data;
                end
                tlk_tx_pkg::st_vld_data: begin
                    if (i_lane_valid) begin
                        o_sym.kind    <= tlk_tx_pkg::sym_data;
                        o_sym.payload <= i_lane;
                        word_cnt      <= word_cnt + 1'b1;
                        if (word_cnt == data_words - 1'b1) state <= tlk_tx_pkg::st_frame_tail;
                    end
                end
                tlk_tx_pkg::st_frame_tail: begin
                    o_sym.kind <= tlk_tx_pkg::sym_checksum;
                    state      <= tlk_tx_pkg::st_end_frame;
                end
                tlk_tx_pkg::st_end_frame: begin
                    o_sym.kind <= tlk_tx_pkg::sym_eof;
                    frame_cnt  <= last_frame ? '0 : frame_cnt + 1'b1;
                    state      <= tlk_tx_pkg::st_gap;
                end
                tlk_tx_pkg::st_gap: begin
                    period_cnt <= period_cnt + 1'b1;
                    if (period_cnt == GAP_LAST) begin
                        state <= last_frame ? tlk_tx_pkg::st_interrupt
                                            : tlk_tx_pkg::st_start_frame;
                    end
                end
                tlk_tx_pkg::st_interrupt: begin
                    // whole periods only, leave once the FIFO has drained
                    if (intr_cnt == i_tx_intr_width - 1'b1) begin
                        intr_cnt <= '0;
                        if (!i_lane_valid) state <= tlk_tx_pkg::st_idle;
                    end else begin
                        intr_cnt <= intr_cnt + 1'b1;
                    end
                end
                default: state <= tlk_tx_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/tlk_symbol_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_symbol_encoder (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  tlk_tx_pkg::tx_sym_t    i_sym,
    output tlk_tx_pkg::line_word_t o_txd,
    output logic                   o_tkmsb,
    output logic                   o_tklsb,
    output logic                   o_enable,
    output logic                   o_lckrefn
);

    tlk_tx_pkg::line_word_t checksum;
    tlk_tx_pkg::line_word_t next_word;
    logic                   next_kmsb;
    logic                   next_klsb;

    // number, length and data carry their payload through
    always_comb begin
        next_word = i_sym.payload;
        next_kmsb = 1'b0;
        next_klsb = 1'b0;
        case (i_sym.kind)
            tlk_tx_pkg::sym_idle: begin
                next_word = tlk_tx_pkg::COMMA_WORD;
                next_klsb = 1'b1;
            end
            tlk_tx_pkg::sym_sof: begin
                next_word = tlk_tx_pkg::SOF_WORD;
                next_kmsb = 1'b1;
                next_klsb = 1'b1;
            end
            tlk_tx_pkg::sym_eof: begin
                next_word = tlk_tx_pkg::EOF_WORD;
                next_kmsb = 1'b1;
                next_klsb = 1'b1;
            end
            tlk_tx_pkg::sym_head0:     next_word = tlk_tx_pkg::HEAD0_WORD;
            tlk_tx_pkg::sym_head1:     next_word = tlk_tx_pkg::HEAD1_WORD;
            tlk_tx_pkg::sym_sign:      next_word = tlk_tx_pkg::SIGN_WORD;
            tlk_tx_pkg::sym_sign_last: next_word = tlk_tx_pkg::SIGN_LAST_WORD;
            tlk_tx_pkg::sym_checksum:  next_word = checksum;
            default: ;
        endcase
    end

    // 16-bit wrapping sum over number, length and data
    always_ff @(posedge clk) begin
        if (i_soft_reset || i_sym.kind == tlk_tx_pkg::sym_sof) begin
            checksum <= '0;
        end else if (i_sym.kind == tlk_tx_pkg::sym_number ||
                     i_sym.kind == tlk_tx_pkg::sym_length ||
                     i_sym.kind == tlk_tx_pkg::sym_data) begin
            checksum <= checksum + i_sym.payload;
        end
    end

    ////////////////////////////////////////////////////////////
    // chip pins
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_txd     <= tlk_tx_pkg::COMMA_WORD;
            o_tkmsb   <= 1'b0;
            o_tklsb   <= 1'b1;
            o_enable  <= 1'b0;
            o_lckrefn <= 1'b0;
        end else begin
            o_txd     <= next_word;
            o_tkmsb   <= next_kmsb;
            o_tklsb   <= next_klsb;
            o_enable  <= 1'b1;
            o_lckrefn <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/tlk_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_top #(
    parameter int FIFO_ADDR_W     = 9,
    parameter int PWR_SYNC_CYCLES = 100,
    parameter int SYNC_CYCLES     = 6,
    parameter int GAP_CYCLES      = 257
) (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  tlk_tx_pkg::byte_len_t  i_tx_packet_body,
    input  tlk_tx_pkg::byte_len_t  i_tx_packet_tail,
    input  tlk_tx_pkg::frame_cnt_t i_tx_body_num,
    input  tlk_tx_pkg::line_word_t i_tx_intr_width,
    input  logic                   i_loopback_ena,
    input  logic                   i_tx_pre,
    input  logic                   i_dma_rd_valid,
    input  tlk_tx_pkg::dma_word_t  i_dma_rd_data,
    output logic                   o_dma_rd_ready,
    output logic                   o_tx_interrupt,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb,
    output logic                   o_2711_enable,
    output logic                   o_2711_lckrefn,
    output logic                   o_2711_loopen,
    output logic                   o_2711_pre,
    output tlk_tx_pkg::line_word_t o_2711_txd
);

    tlk_tx_pkg::dma_word_t  fifo_head;
    tlk_tx_pkg::line_word_t lane;
    tlk_tx_pkg::tx_sym_t    sym;
    logic                   fifo_full;
    logic                   fifo_not_empty;
    logic                   fifo_pop;
    logic                   lane_valid;
    logic                   lane_next;
    logic                   frame_end;

    assign o_dma_rd_ready = ~fifo_full;
    assign o_2711_loopen  = i_loopback_ena;
    assign o_2711_pre     = i_tx_pre;

    tlk_tx_fifo #(.ADDR_W(FIFO_ADDR_W)) fifo_i (
        .clk(clk), .i_soft_reset(i_soft_reset),
        .i_wr_en(i_dma_rd_valid & o_dma_rd_ready), .i_wr_data(i_dma_rd_data),
        .i_pop(fifo_pop), .o_head(fifo_head),
        .o_not_empty(fifo_not_empty), .o_full(fifo_full)
    );

    tlk_lane_unpacker unpacker_i (
        .clk(clk), .i_soft_reset(i_soft_reset),
        .i_head(fifo_head), .i_not_empty(fifo_not_empty),
        .i_lane_next(lane_next), .i_frame_end(frame_end),
        .o_lane(lane), .o_lane_valid(lane_valid), .o_pop(fifo_pop)
    );

    tlk_tx_framer #(
        .PWR_SYNC_CYCLES(PWR_SYNC_CYCLES),
        .SYNC_CYCLES(SYNC_CYCLES),
        .GAP_CYCLES(GAP_CYCLES)
    ) framer_i (
        .clk(clk), .i_soft_reset(i_soft_reset), .i_tx_start(i_tx_start),
        .i_tx_packet_body(i_tx_packet_body), .i_tx_packet_tail(i_tx_packet_tail),
        .i_tx_body_num(i_tx_body_num), .i_tx_intr_width(i_tx_intr_width),
        .i_lane(lane), .i_lane_valid(lane_valid),
        .o_lane_next(lane_next), .o_frame_end(frame_end),
        .o_sym(sym), .o_tx_interrupt(o_tx_interrupt)
    );

    tlk_symbol_encoder encoder_i (
        .clk(clk), .i_soft_reset(i_soft_reset), .i_sym(sym),
        .o_txd(o_2711_txd), .o_tkmsb(o_2711_tkmsb), .o_tklsb(o_2711_tklsb),
        .o_enable(o_2711_enable), .o_lckrefn(o_2711_lckrefn)
    );

endmodule

`default_nettype wire

// File: tests/tlk_tx_frame_model.svh
`ifndef TLK_TX_FRAME_MODEL_SVH
`define TLK_TX_FRAME_MODEL_SVH

// one sampled line cycle
typedef struct packed {
    tlk_tx_pkg::line_word_t txd;
    logic                   kmsb;
    logic                   klsb;
    logic                   intr;
} line_beat_t;

// data lanes as loaded, padding lanes left out
tlk_tx_pkg::line_word_t file_lanes[$];
line_beat_t             expected[$];

// line cycles of one file, starting at the first sof
task automatic build_expected(input int body, input int tail, input int frames_last,
                              input int intr_width, input int gap);
    int                     f;
    int                     i;
    int                     k;
    int                     len;
    int                     lane_pos;
    int                     tail_beats;
    tlk_tx_pkg::line_word_t sum;
    expected.delete();
    lane_pos = 0;
    for (f = 0; f <= frames_last; f++) begin
        len = (f == frames_last) ? tail : body;
        sum = f[15:0] + len[15:0];
        expected.push_back({16'h5CFB, 3'b110});
        expected.push_back({16'hEB90, 3'b000});
        expected.push_back({16'hE116, 3'b000});
        expected.push_back({(f == frames_last) ? 16'h8101 : 16'h8100, 3'b000});
        expected.push_back({f[15:0], 3'b000});
        expected.push_back({len[15:0], 3'b000});
        for (i = 0; i < (len + 1) / 2; i++) begin
            expected.push_back({file_lanes[lane_pos], 3'b000});
            sum = sum + file_lanes[lane_pos];
            lane_pos++;
        end
        expected.push_back({sum, 3'b000});
        expected.push_back({16'hFDFE, 3'b110});
        // interrupt comes from the state, so it leads the line by two cycles
        tail_beats = (f == frames_last) ? gap + intr_width + 1 : gap;
        for (k = 1; k <= tail_beats; k++) begin
            expected.push_back({16'hC5BC, 2'b01, (f == frames_last) && (k >= gap - 1) &&
                                (k <= gap + intr_width - 2)});
        end
    end
endtask

`endif

// File: tests/tlk_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlk_tx_tb;

    localparam int FIFO_ADDR_W     = 5;
    localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_W;
    localparam int PWR_SYNC_CYCLES = 100;
    localparam int SYNC_CYCLES     = 6;
    localparam int GAP_CYCLES      = 20;
    localparam int NUM_CASES       = 5;
    localparam int WAIT_LIMIT      = 2000;

    // intr_at counts line cycles from the first sof to the interrupt
    typedef struct packed {
        tlk_tx_pkg::byte_len_t  body;
        tlk_tx_pkg::byte_len_t  tail;
        tlk_tx_pkg::frame_cnt_t num;
        tlk_tx_pkg::line_word_t width;
        tlk_tx_pkg::line_word_t intr_at;
    } case_t;

    logic                   clk;
    logic                   i_soft_reset;
    logic                   i_tx_start;
    tlk_tx_pkg::byte_len_t  i_tx_packet_body;
    tlk_tx_pkg::byte_len_t  i_tx_packet_tail;
    tlk_tx_pkg::frame_cnt_t i_tx_body_num;
    tlk_tx_pkg::line_word_t i_tx_intr_width;
    logic                   i_loopback_ena;
    logic                   i_tx_pre;
    logic                   i_dma_rd_valid;
    tlk_tx_pkg::dma_word_t  i_dma_rd_data;
    logic                   o_dma_rd_ready;
    logic                   o_tx_interrupt;
    logic                   o_2711_tkmsb;
    logic                   o_2711_tklsb;
    logic                   o_2711_enable;
    logic                   o_2711_lckrefn;
    logic                   o_2711_loopen;
    logic                   o_2711_pre;
    tlk_tx_pkg::line_word_t o_2711_txd;
    int unsigned            seed;
    int unsigned            seed_ret;

    `include "tlk_tx_frame_model.svh"

    tlk_tx_top #(
        .FIFO_ADDR_W(FIFO_ADDR_W),
        .PWR_SYNC_CYCLES(PWR_SYNC_CYCLES),
        .SYNC_CYCLES(SYNC_CYCLES),
        .GAP_CYCLES(GAP_CYCLES)
    ) dut_i (
        .clk(clk), .i_soft_reset(i_soft_reset), .i_tx_start(i_tx_start),
        .i_tx_packet_body(i_tx_packet_body), .i_tx_packet_tail(i_tx_packet_tail),
        .i_tx_body_num(i_tx_body_num), .i_tx_intr_width(i_tx_intr_width),
        .i_loopback_ena(i_loopback_ena), .i_tx_pre(i_tx_pre),
        .i_dma_rd_valid(i_dma_rd_valid), .i_dma_rd_data(i_dma_rd_data),
        .o_dma_rd_ready(o_dma_rd_ready), .o_tx_interrupt(o_tx_interrupt),
        .o_2711_tkmsb(o_2711_tkmsb), .o_2711_tklsb(o_2711_tklsb),
        .o_2711_enable(o_2711_enable), .o_2711_lckrefn(o_2711_lckrefn),
        .o_2711_loopen(o_2711_loopen), .o_2711_pre(o_2711_pre), .o_2711_txd(o_2711_txd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // case table
    ////////////////////////////////////////////////////////////

    // body, tail, last frame number, interrupt width, interrupt start
    function automatic case_t case_row(input int row);
        case (row)
            0:       case_row = {16'd16, 16'd16, 24'd0, 16'd4, 16'd34};
            1:       case_row = {16'd10, 16'd7,  24'd2, 16'd3, 16'd96};
            2:       case_row = {16'd9,  16'd3,  24'd1, 16'd1, 16'd61};
            3:       case_row = {16'd64, 16'd33, 24'd3, 16'd5, 16'd223};
            default: case_row = {16'd2,  16'd1,  24'd4, 16'd2, 16'd143};
        endcase
    endfunction

    task automatic stop_with_fail;
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input tlk_tx_pkg::line_word_t exp_w,
                              input tlk_tx_pkg::line_word_t act_w);
        if (exp_w !== act_w) begin
            $display("FAILED %s expected %h actual %h", name, exp_w, act_w);
            stop_with_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_b, input logic act_b);
        if (exp_b !== act_b) begin
            $display("FAILED %s expected %b actual %b", name, exp_b, act_b);
            stop_with_fail();
        end
    endtask

    task automatic check_idle_line(input string name, input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            check_word($sformatf("%s txd", name), 16'hC5BC, o_2711_txd);
            check_bit($sformatf("%s tkmsb", name), 1'b0, o_2711_tkmsb);
            check_bit($sformatf("%s tklsb", name), 1'b1, o_2711_tklsb);
            check_bit($sformatf("%s interrupt", name), 1'b0, o_tx_interrupt);
            check_bit($sformatf("%s enable", name), 1'b1, o_2711_enable);
            check_bit($sformatf("%s lckrefn", name), 1'b1, o_2711_lckrefn);
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // DMA driver and line monitor
    ////////////////////////////////////////////////////////////

    // every frame starts on a fresh 64-bit word
    task automatic load_file(input case_t c);
        int                    f;
        int                    w;
        int                    l;
        int                    lanes;
        int                    tries;
        tlk_tx_pkg::dma_word_t word;
        file_lanes.delete();
        i_tx_packet_body = c.body;
        i_tx_packet_tail = c.tail;
        i_tx_body_num    = c.num;
        i_tx_intr_width  = c.width;
        for (f = 0; f <= int'(c.num); f++) begin
            lanes = ((f == int'(c.num)) ? int'(c.tail) + 1 : int'(c.body) + 1) / 2;
            for (w = 0; w < (lanes + 3) / 4; w++) begin
                word = {$urandom, $urandom};
                for (l = 0; l < 4; l++) begin
                    if (w * 4 + l < lanes) file_lanes.push_back(word[16 * l +: 16]);
                end
                i_dma_rd_valid = 1'b1;
                i_dma_rd_data  = word;
                tries = 0;
                while (!o_dma_rd_ready) begin
                    @(negedge clk);
                    tries++;
                    if (tries > WAIT_LIMIT) begin
                        $display("timeout: DMA ready stayed low while loading a file");
                        stop_with_fail();
                    end
                end
                @(negedge clk);
            end
        end
        i_dma_rd_valid = 1'b0;
    endtask

    // random words with no frame meaning
    task automatic write_words(input int count);
        int n;
        int tries;
        for (n = 0; n < count; n++) begin
            i_dma_rd_valid = 1'b1;
            i_dma_rd_data  = {$urandom, $urandom};
            tries = 0;
            while (!o_dma_rd_ready) begin
                @(negedge clk);
                tries++;
                if (tries > WAIT_LIMIT) begin
                    $display("timeout: DMA ready stayed low while writing words");
                    stop_with_fail();
                end
            end
            @(negedge clk);
        end
        i_dma_rd_valid = 1'b0;
    endtask

    task automatic pulse_start;
        i_tx_start = 1'b1;
        @(negedge clk);
        i_tx_start = 1'b0;
    endtask

    task automatic wait_for_sof;
        int tries;
        tries = 0;
        while (!(o_2711_txd === 16'h5CFB && o_2711_tkmsb === 1'b1)) begin
            @(negedge clk);
            tries++;
            if (tries > WAIT_LIMIT) begin
                $display("timeout: no start of frame appeared on the line");
                stop_with_fail();
            end
        end
    endtask

    task automatic run_file(input int row, input case_t c);
        int                     idx;
        tlk_tx_pkg::line_word_t rise;
        line_beat_t             exp_b;
        build_expected(c.body, c.tail, c.num, c.width, GAP_CYCLES);
        rise = 16'hFFFF;
        wait_for_sof();
        for (idx = 0; idx < expected.size(); idx++) begin
            exp_b = expected[idx];
            check_word($sformatf("case %0d beat %0d txd", row, idx), exp_b.txd, o_2711_txd);
            check_bit($sformatf("case %0d beat %0d tkmsb", row, idx), exp_b.kmsb, o_2711_tkmsb);
            check_bit($sformatf("case %0d beat %0d tklsb", row, idx), exp_b.klsb, o_2711_tklsb);
            check_bit($sformatf("case %0d beat %0d interrupt", row, idx), exp_b.intr,
                      o_tx_interrupt);
            if (o_tx_interrupt && rise == 16'hFFFF) rise = idx[15:0];
            @(negedge clk);
        end
        check_word($sformatf("case %0d interrupt start", row), c.intr_at, rise);
    endtask

    initial begin
        int    row;
        case_t c;
        seed     = 32'h3a34;
        seed_ret = $urandom(seed);
        i_soft_reset     = 1'b1;
        i_tx_start       = 1'b0;
        i_tx_packet_body = '0;
        i_tx_packet_tail = '0;
        i_tx_body_num    = '0;
        i_tx_intr_width  = 16'd1;
        i_loopback_ena   = 1'b1;
        i_tx_pre         = 1'b0;
        i_dma_rd_valid   = 1'b0;
        i_dma_rd_data    = '0;
        repeat (10) @(negedge clk);
        check_bit("reset enable", 1'b0, o_2711_enable);
        check_bit("reset lckrefn", 1'b0, o_2711_lckrefn);
        i_soft_reset = 1'b0;
        @(negedge clk);
        check_bit("loopen pass", 1'b1, o_2711_loopen);
        check_bit("pre pass", 1'b0, o_2711_pre);
        i_loopback_ena = 1'b0;
        i_tx_pre       = 1'b1;
        @(negedge clk);
        check_bit("loopen low pass", 1'b0, o_2711_loopen);
        check_bit("pre high pass", 1'b1, o_2711_pre);
        check_idle_line("after reset", 8);

        for (row = 0; row < NUM_CASES; row++) begin
            c = case_row(row);
            load_file(c);
            pulse_start();
            run_file(row, c);
        end

        // start held high, a refill alone must not send
        c = case_row(1);
        load_file(c);
        i_tx_start = 1'b1;
        @(negedge clk);
        run_file(10, c);
        load_file(c);
        check_idle_line("start held", 60);
        i_tx_start = 1'b0;
        @(negedge clk);
        pulse_start();
        run_file(11, c);

        // a full FIFO holds the source off until soft reset empties it
        write_words(FIFO_DEPTH);
        check_bit("fifo full ready", 1'b0, o_dma_rd_ready);
        i_soft_reset = 1'b1;
        @(negedge clk);
        i_soft_reset = 1'b0;
        check_bit("soft reset ready", 1'b1, o_dma_rd_ready);

        // soft reset part way into the data of a frame
        c = case_row(3);
        load_file(c);
        pulse_start();
        wait_for_sof();
        repeat (10) @(negedge clk);
        i_soft_reset = 1'b1;
        @(negedge clk);
        i_soft_reset = 1'b0;
        @(negedge clk);
        check_idle_line("soft reset", 30);
        load_file(c);
        pulse_start();
        run_file(12, c);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlk_tx.f
+incdir+tests
logic/tlk_tx_pkg.sv
logic/tlk_tx_fifo.sv
logic/tlk_lane_unpacker.sv
logic/tlk_tx_framer.sv
logic/tlk_symbol_encoder.sv
logic/tlk_tx_top.sv
tests/tlk_tx_tb.sv
